// ==== hdl/fp_add_decode.sv ====
// combinational unpack and align for the first half of the add
// a subnormal operand is read with exponent 1 and no hidden bit
`timescale 1ns/1ps

module fp_add_decode import fp_add_pkg::*; (
	input  fp_word_t in_1,
	input  fp_word_t in_2,
	input  logic sub,
	input  logic start,
	output logic [MANT_W-1:0] mant_1,
	output logic [MANT_W-1:0] mant_2,
	output logic sign_1,
	output logic sign_2,
	output logic [EXP_W-1:0] exponent,
	output logic nan,
	output logic infinity,
	output logic infinity_sign,
	output logic snan,
	output logic zero_same_sign
);
	logic boxed_1, boxed_2;
	logic exp_ones_1, exp_ones_2;
	logic frac_zero_1, frac_zero_2;
	logic is_nan_1, is_nan_2;
	logic is_inf_1, is_inf_2;
	logic is_zero_1, is_zero_2;
	logic [EXP_W-1:0] rexp_1, rexp_2;
	logic [MANT_W-1:0] raw_mant_1, raw_mant_2;
	logic exp_gt;
	logic [EXP_W-1:0] exp_diff;

	// right shift with everything that falls off the end landing in the sticky bit
	function automatic logic [MANT_W-1:0] align(input logic [MANT_W-1:0] m,
		input logic [EXP_W-1:0] sh);
		logic [2*MANT_W-1:0] ext;
		logic [EXP_W-1:0] sh_c;
		sh_c = (sh > EXP_W'(MANT_W)) ? EXP_W'(MANT_W) : sh;
		ext = {m, {MANT_W{1'b0}}} >> sh_c;
		return {ext[2*MANT_W-1:MANT_W+1], ext[MANT_W] | (|ext[MANT_W-1:0])};
	endfunction

	assign boxed_1 = &in_1.f.box;
	assign boxed_2 = &in_2.f.box;
	assign exp_ones_1 = in_1.f.exp == EXP_MAX;
	assign exp_ones_2 = in_2.f.exp == EXP_MAX;
	assign frac_zero_1 = in_1.f.frac == '0;
	assign frac_zero_2 = in_2.f.frac == '0;

	assign is_nan_1 = !boxed_1 || (exp_ones_1 && !frac_zero_1);
	assign is_nan_2 = !boxed_2 || (exp_ones_2 && !frac_zero_2);
	assign is_inf_1 = boxed_1 && exp_ones_1 && frac_zero_1;
	assign is_inf_2 = boxed_2 && exp_ones_2 && frac_zero_2;
	assign is_zero_1 = (in_1.f.exp == '0) && frac_zero_1;
	assign is_zero_2 = (in_2.f.exp == '0) && frac_zero_2;

	assign sign_1 = in_1.f.sign;
	assign sign_2 = in_2.f.sign ^ (sub & ~is_nan_2);	// NaN keeps its sign

	// quiet bit clear means signalling and unboxed words never signal
	assign snan = (boxed_1 && exp_ones_1 && !frac_zero_1 && !in_1.f.frac[FRAC_W-1]) ||
		(boxed_2 && exp_ones_2 && !frac_zero_2 && !in_2.f.frac[FRAC_W-1]);
	assign nan = is_nan_1 || is_nan_2 || (is_inf_1 && is_inf_2 && (sign_1 != sign_2));
	assign infinity = is_inf_1 || is_inf_2;
	assign infinity_sign = (is_inf_1 & sign_1) | (is_inf_2 & sign_2);
	assign zero_same_sign = is_zero_1 && is_zero_2 && (sign_1 == sign_2);

	assign rexp_1 = (in_1.f.exp == '0) ? EXP_W'(1) : in_1.f.exp;
	assign rexp_2 = (in_2.f.exp == '0) ? EXP_W'(1) : in_2.f.exp;
	assign raw_mant_1 = {in_1.f.exp != '0, in_1.f.frac, 3'b000};
	assign raw_mant_2 = {in_2.f.exp != '0, in_2.f.frac, 3'b000};

	assign exp_gt = rexp_1 > rexp_2;
	assign exp_diff = exp_gt ? (rexp_1 - rexp_2) : (rexp_2 - rexp_1);

	// equal exponents take the second branch with a zero shift
	assign mant_1 = exp_gt ? raw_mant_1 : align(raw_mant_1, exp_diff);
	assign mant_2 = exp_gt ? align(raw_mant_2, exp_diff) : raw_mant_2;
	assign exponent = exp_gt ? rexp_1 : rexp_2;

	// finite operands never carry the all-ones exponent into execute
	always_comb begin
		if (start)
			assert final (nan || infinity || exponent != EXP_MAX)
			else $error("finite operands produced an all-ones exponent");
	end

endmodule

// ==== hdl/fp_add_execute.sv ====
// signed mantissa add, then the single pipeline register
// the registered sum is already a magnitude with its sign split off
`timescale 1ns/1ps

module fp_add_execute import fp_add_pkg::*; #(
	parameter int TAG_W = 6
) (
	input  logic clk,
	input  logic reset,
	input  logic [MANT_W-1:0] mant_1,
	input  logic [MANT_W-1:0] mant_2,
	input  logic sign_1,
	input  logic sign_2,
	input  logic [EXP_W-1:0] exponent,
	input  logic nan,
	input  logic infinity,
	input  logic infinity_sign,
	input  logic snan,
	input  logic zero_same_sign,
	input  rnd_t rnd,
	input  logic [TAG_W-1:0] tag,
	output logic [MANT_W:0] sum,
	output logic sum_sign,
	output logic [EXP_W-1:0] r_exponent,
	output logic r_nan,
	output logic r_infinity,
	output logic r_infinity_sign,
	output logic r_snan,
	output logic r_zero_same_sign,
	output rnd_t r_rnd,
	output logic [TAG_W-1:0] tag_out
);
	logic [MANT_W:0] add_1, add_2;
	logic cin;
	logic sign_x;
	logic [MANT_W+1:0] raw_sum;
	logic neg;
	logic [MANT_W:0] mag;

	always_comb begin
		add_1 = {1'b0, mant_1};
		add_2 = {1'b0, mant_2};
		cin = 1'b0;
		sign_x = sign_1 & sign_2;	// both negative, add magnitudes
		if (sign_1 != sign_2) begin
			cin = 1'b1;	// ones complement plus carry-in
			if (sign_1)
				add_1 = ~add_1;
			else
				add_2 = ~add_2;
		end
	end

	assign raw_sum = {add_1[MANT_W], add_1} + {add_2[MANT_W], add_2} +
		{{(MANT_W+1){1'b0}}, cin};
	assign neg = raw_sum[MANT_W+1];
	assign mag = neg ? (~raw_sum[MANT_W:0] + 1'b1) : raw_sum[MANT_W:0];

	always_ff @(posedge clk) begin
		sum <= mag;
		sum_sign <= sign_x ^ neg;
		r_exponent <= exponent;
		tag_out <= tag;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r_nan <= 1'b0;
			r_infinity <= 1'b0;
			r_infinity_sign <= 1'b0;
			r_snan <= 1'b0;
			r_zero_same_sign <= 1'b0;
			r_rnd <= RNE;
		end else begin
			r_nan <= nan;
			r_infinity <= infinity;
			r_infinity_sign <= infinity_sign;
			r_snan <= snan;
			r_zero_same_sign <= zero_same_sign;
			r_rnd <= rnd;
		end
	end

endmodule

// ==== hdl/fp_add_pkg.sv ====
// single-precision values NaN-boxed in a 64-bit register word
// a word whose upper half is not all ones is treated as a NaN
package fp_add_pkg;

	localparam int XLEN = 64;	// register word
	localparam int EXP_W = 8;
	localparam int FRAC_W = 23;

	// hidden bit, fraction, then guard/round/sticky
	localparam int MANT_W = FRAC_W + 4;

	localparam logic [EXP_W-1:0] EXP_MAX = '1;	// infinity or NaN

	// boxed canonical quiet NaN
	localparam logic [XLEN-1:0] CANON_NAN = 64'hffff_ffff_7fc0_0000;

	// RISC-V frm encoding
	typedef enum logic [2:0] {
		RNE = 3'd0,	// nearest, ties to even
		RTZ = 3'd1,
		RDN = 3'd2,	// toward -inf
		RUP = 3'd3,	// toward +inf
		RMM = 3'd4	// nearest, ties away from zero
	} rnd_t;

	// one register word, seen raw or split into the single fields
	typedef union packed {
		logic [XLEN-1:0] raw;
		struct packed {
			logic [XLEN-EXP_W-FRAC_W-2:0] box;	// all ones when properly boxed
			logic sign;
			logic [EXP_W-1:0] exp;
			logic [FRAC_W-1:0] frac;
		} f;
	} fp_word_t;

endpackage

// ==== hdl/fp_add_result.sv ====
// combinational normalize, round and pack of the registered sum
// the result is always NaN-boxed and NaN results are the canonical quiet NaN
`timescale 1ns/1ps

module fp_add_result import fp_add_pkg::*; (
	input  logic [MANT_W:0] sum,
	input  logic sum_sign,
	input  logic [EXP_W-1:0] r_exponent,
	input  logic r_nan,
	input  logic r_infinity,
	input  logic r_infinity_sign,
	input  logic r_snan,
	input  logic r_zero_same_sign,
	input  rnd_t r_rnd,
	output fp_word_t res,
	output logic exception
);
	localparam int LZ_W = $clog2(MANT_W + 1);

	logic [LZ_W-1:0] lz;
	logic [EXP_W-1:0] lz_e;
	logic [LZ_W-1:0] shl;
	logic [EXP_W:0] exp_t;
	logic [MANT_W-1:0] mant_z;
	logic [2:0] grs;
	logic round_up;
	logic [FRAC_W+1:0] sig_r;	// carry, hidden bit, fraction
	logic [EXP_W:0] exp_f;
	logic is_zero;
	logic overflow;
	logic to_max;
	logic rsign;

	function automatic logic [LZ_W-1:0] lzc(input logic [MANT_W-1:0] m);
		logic [LZ_W-1:0] n;
		n = LZ_W'(MANT_W);
		for (int i = 0; i < MANT_W; i++)
			if (m[i])
				n = LZ_W'(MANT_W - 1 - i);
		return n;
	endfunction

	assign lz = lzc(sum[MANT_W-1:0]);
	assign lz_e = EXP_W'(lz);

	always_comb begin
		if (sum[MANT_W]) begin
			shl = '0;
			exp_t = {1'b0, r_exponent} + 1'b1;	// carry out so shift right by one
		end else if (lz_e < r_exponent) begin
			shl = lz;
			exp_t = {1'b0, r_exponent} - {1'b0, lz_e};
		end else begin
			// can't reach the hidden bit without going below exponent 1
			shl = LZ_W'(r_exponent - 1'b1);
			exp_t = '0;
		end
	end

	assign mant_z = sum[MANT_W] ? {sum[MANT_W:2], sum[1] | sum[0]} : (sum[MANT_W-1:0] << shl);
	assign grs = mant_z[2:0];

	always_comb begin
		case (r_rnd)
			RNE: round_up = grs[2] & ((|grs[1:0]) | mant_z[3]);
			RTZ: round_up = 1'b0;
			RDN: round_up = sum_sign & (|grs);
			RUP: round_up = !sum_sign & (|grs);
			RMM: round_up = grs[2];
			default: round_up = 1'b0;
		endcase
	end

	assign sig_r = {1'b0, mant_z[MANT_W-1:3]} + {{(FRAC_W+1){1'b0}}, round_up};

	always_comb begin
		if (exp_t == '0)
			exp_f = {{EXP_W{1'b0}}, sig_r[FRAC_W]};	// subnormal rounded up to normal
		else
			exp_f = exp_t + {{EXP_W{1'b0}}, sig_r[FRAC_W+1]};
	end

	assign is_zero = sum == '0;
	assign overflow = !is_zero && (exp_f >= {1'b0, EXP_MAX});

	// exact cancellation gives +0 except -0 when rounding down
	assign rsign = is_zero ? (r_zero_same_sign ? sum_sign : (r_rnd == RDN)) : sum_sign;

	always_comb begin
		case (r_rnd)
			RTZ: to_max = 1'b1;
			RDN: to_max = !sum_sign;
			RUP: to_max = sum_sign;
			default: to_max = 1'b0;	// nearest modes go to infinity
		endcase
	end

	always_comb begin
		res.raw = CANON_NAN;
		if (!r_nan) begin
			if (!r_infinity && overflow && to_max) begin
				res.f.sign = sum_sign;
				res.f.exp = EXP_MAX - 1'b1;	// largest finite
				res.f.frac = '1;
			end else if (r_infinity || overflow) begin
				res.f.sign = r_infinity ? r_infinity_sign : sum_sign;
				res.f.exp = EXP_MAX;
				res.f.frac = '0;
			end else begin
				res.f.sign = rsign;
				res.f.exp = is_zero ? '0 : exp_f[EXP_W-1:0];
				res.f.frac = sig_r[FRAC_W-1:0];
			end
		end
	end

	assign exception = r_snan;	// invalid only from a signalling input

	// a signalling input always ends in the canonical NaN
	always_comb begin
		if (exception)
			assert final (res.raw == CANON_NAN)
			else $error("signalling input did not give the canonical NaN");
	end

endmodule

// ==== hdl/fp_add_sub.sv ====
// single-precision add/subtract, one clock from start to valid
// no back-pressure; start may be held every cycle
`timescale 1ns/1ps

module fp_add_sub import fp_add_pkg::*; #(
	parameter int TAG_W = 6
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic sub,
	input  rnd_t rnd,
	input  fp_word_t in_1,
	input  fp_word_t in_2,
	input  logic [TAG_W-1:0] tag,
	output logic valid,
	output logic exception,
	output fp_word_t res,
	output logic [TAG_W-1:0] tag_out
);
	logic [MANT_W-1:0] mant_1, mant_2;
	logic sign_1, sign_2;
	logic [EXP_W-1:0] exponent;
	logic nan, infinity, infinity_sign, snan, zero_same_sign;
	logic [MANT_W:0] sum;
	logic sum_sign;
	logic [EXP_W-1:0] r_exponent;
	logic r_nan, r_infinity, r_infinity_sign, r_snan, r_zero_same_sign;
	rnd_t r_rnd;

	always_ff @(posedge clk) begin
		if (reset)
			valid <= 1'b0;
		else
			valid <= start;	// same delay as the execute register
	end

	fp_add_decode decode_i (
		.in_1(in_1), .in_2(in_2), .sub(sub), .start(start),
		.mant_1(mant_1), .mant_2(mant_2), .sign_1(sign_1), .sign_2(sign_2),
		.exponent(exponent), .nan(nan), .infinity(infinity),
		.infinity_sign(infinity_sign), .snan(snan), .zero_same_sign(zero_same_sign)
	);

	fp_add_execute #(.TAG_W(TAG_W)) execute_i (
		.clk(clk), .reset(reset),
		.mant_1(mant_1), .mant_2(mant_2), .sign_1(sign_1), .sign_2(sign_2),
		.exponent(exponent), .nan(nan), .infinity(infinity),
		.infinity_sign(infinity_sign), .snan(snan), .zero_same_sign(zero_same_sign),
		.rnd(rnd), .tag(tag),
		.sum(sum), .sum_sign(sum_sign), .r_exponent(r_exponent), .r_nan(r_nan),
		.r_infinity(r_infinity), .r_infinity_sign(r_infinity_sign), .r_snan(r_snan),
		.r_zero_same_sign(r_zero_same_sign), .r_rnd(r_rnd), .tag_out(tag_out)
	);

	fp_add_result result_i (
		.sum(sum), .sum_sign(sum_sign), .r_exponent(r_exponent), .r_nan(r_nan),
		.r_infinity(r_infinity), .r_infinity_sign(r_infinity_sign), .r_snan(r_snan),
		.r_zero_same_sign(r_zero_same_sign), .r_rnd(r_rnd),
		.res(res), .exception(exception)
	);

	// the rounding mode reaching the result stage must be a legal code
	assert property (@(posedge clk) disable iff (reset) start |=> (r_rnd <= RMM))
	else $error("illegal rounding mode in result stage");

endmodule

// ==== tb.f ====
+incdir+testbench
hdl/fp_add_pkg.sv
hdl/fp_add_decode.sv
hdl/fp_add_execute.sv
hdl/fp_add_result.sv
hdl/fp_add_sub.sv
testbench/fp_add_tb.sv

// ==== testbench/fp_add_ref.svh ====
// expected results for the single-precision add, taken from exact real sums
// exact only while the operand exponents differ by at most 24
`ifndef FP_ADD_REF_SVH
`define FP_ADD_REF_SVH

localparam logic [63:0] QNAN = 64'hffff_ffff_7fc0_0000;

function automatic logic is_snan(input logic [63:0] w);
	return w[63:32] == 32'hffff_ffff && w[30:23] == 8'hff && w[22:0] != 0 && !w[22];
endfunction

function automatic logic is_nan(input logic [63:0] w);
	return w[63:32] != 32'hffff_ffff || (w[30:23] == 8'hff && w[22:0] != 0);
endfunction

function automatic logic is_inf(input logic [63:0] w);
	return !is_nan(w) && w[30:0] == 31'h7f80_0000;
endfunction

// value of a single as a real, subnormals read with exponent 1
function automatic real single_val(input logic [31:0] w);
	logic [31:0] m;
	int e;
	real v;
	m = {8'd0, w[30:23] != 0, w[22:0]};
	e = (w[30:23] != 0) ? int'(w[30:23]) : 1;
	v = real'(m) * (2.0 ** (e - 150));
	return w[31] ? -v : v;
endfunction

// round a nonzero double to single by the given mode
function automatic logic [31:0] round_single(input real r, input logic [2:0] mode);
	logic [63:0] d;
	logic [63:0] sig;
	logic [63:0] kept;
	logic [31:0] mag;
	logic s, half, sticky, inc, to_max;
	int e, sh;
	d = $realtobits(r);
	s = d[63];
	e = int'(d[62:52]) - 1023 + 127;	// biased single exponent
	sig = {11'd0, 1'b1, d[51:0]};
	sh = (e >= 1) ? 29 : 30 - e;	// extra shift for subnormal results
	if (sh > 55)
		sh = 55;
	kept = sig >> sh;
	half = sig[sh-1];
	sticky = (sig & ((64'd1 << (sh - 1)) - 64'd1)) != 0;
	case (mode)
		3'd0: inc = half & (sticky | kept[0]);
		3'd1: inc = 1'b0;
		3'd2: inc = s & (half | sticky);
		3'd3: inc = !s & (half | sticky);
		default: inc = half;
	endcase
	// hidden bit and mantissa carry both spill into the exponent field
	mag = 32'(((e >= 1) ? (64'(e - 1) << 23) : 64'd0) + kept + 64'(inc));
	if (mag >= 32'h7f80_0000) begin
		to_max = (mode == 3'd1) || (mode == 3'd2 && !s) || (mode == 3'd3 && s);
		return {s, to_max ? 31'h7f7f_ffff : 31'h7f80_0000};
	end
	return {s, mag[30:0]};
endfunction

function automatic logic [63:0] expect_res(input logic [63:0] a, input logic [63:0] b,
	input logic s, input logic [2:0] mode);
	logic sa, sb, zs;
	real r;
	sa = a[31];
	sb = b[31] ^ s;	// effective sign of the second operand
	if (is_nan(a) || is_nan(b))
		return QNAN;
	if (is_inf(a) && is_inf(b))
		return (sa == sb) ? {32'hffff_ffff, sa, 31'h7f80_0000} : QNAN;
	if (is_inf(a))
		return {32'hffff_ffff, sa, 31'h7f80_0000};
	if (is_inf(b))
		return {32'hffff_ffff, sb, 31'h7f80_0000};
	r = single_val(a[31:0]) + (s ? -single_val(b[31:0]) : single_val(b[31:0]));
	if (r == 0.0) begin
		zs = (a[30:0] == 0 && b[30:0] == 0 && sa == sb) ? sa : (mode == 3'd2);
		return {32'hffff_ffff, zs, 31'd0};
	end
	return {32'hffff_ffff, round_single(r, mode)};
endfunction

function automatic logic expect_exc(input logic [63:0] a, input logic [63:0] b);
	return is_snan(a) || is_snan(b);
endfunction

`endif

// ==== testbench/fp_add_tb.sv ====
// drives the add/subtract unit and checks each result one cycle after its start
// random operands keep exponents within 24 of each other
`timescale 1ns/1ps

module fp_add_tb import fp_add_pkg::*; ();
	localparam int N_RAND = 400;
	localparam int N_FIXED = 80;	// directed operations plus idle gaps
	localparam logic [63:0] PMAX = 64'hffff_ffff_7f7f_ffff;
	localparam logic [63:0] NMAX = 64'hffff_ffff_ff7f_ffff;
	localparam logic [63:0] PINF = 64'hffff_ffff_7f80_0000;
	localparam logic [63:0] NINF = 64'hffff_ffff_ff80_0000;
	localparam logic [63:0] SNAN = 64'hffff_ffff_7fa0_0000;
	localparam logic [63:0] ONE = 64'hffff_ffff_3f80_0000;
	localparam logic [63:0] PZERO = 64'hffff_ffff_0000_0000;
	localparam logic [63:0] NZERO = 64'hffff_ffff_8000_0000;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic start = 1'b1;	// held high while reset is asserted
	logic sub = 1'b0;
	rnd_t rnd = RNE;
	logic [63:0] in_1 = '0;
	logic [63:0] in_2 = '0;
	logic [5:0] tag = '0;
	logic valid, exception;
	logic [63:0] res;
	logic [5:0] tag_out;
	logic [63:0] pend_res = '0;
	logic [63:0] slot_res = '0;
	logic pend_exc = 1'b0;
	logic slot_exc = 1'b0;
	logic slot_valid = 1'b0;
	logic [5:0] pend_tag = '0;
	logic [5:0] slot_tag = '0;

	`include "fp_add_ref.svh"

	always #4 clk = ~clk;

	fp_add_sub #(.TAG_W(6)) dut_i (
		.clk(clk), .reset(reset), .start(start), .sub(sub), .rnd(rnd),
		.in_1(in_1), .in_2(in_2), .tag(tag),
		.valid(valid), .exception(exception), .res(res), .tag_out(tag_out)
	);

	// expected values for the operation now in the result stage
	always @(posedge clk) begin
		slot_valid <= start & !reset;
		slot_res <= pend_res;
		slot_exc <= pend_exc;
		slot_tag <= pend_tag;
	end

	task automatic stop_fail();
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	assert property (@(posedge clk) disable iff (reset) valid == slot_valid)
	else begin
		$display("CHECK FAILED time=%0t signal=valid expected=%b actual=%b",
			$time, $sampled(slot_valid), $sampled(valid));
		stop_fail();
	end

	assert property (@(posedge clk) disable iff (reset) slot_valid |-> res == slot_res)
	else begin
		$display("CHECK FAILED time=%0t signal=res expected=%h actual=%h",
			$time, $sampled(slot_res), $sampled(res));
		stop_fail();
	end

	assert property (@(posedge clk) disable iff (reset) slot_valid |-> exception == slot_exc)
	else begin
		$display("CHECK FAILED time=%0t signal=exception expected=%b actual=%b",
			$time, $sampled(slot_exc), $sampled(exception));
		stop_fail();
	end

	assert property (@(posedge clk) disable iff (reset) slot_valid |-> tag_out == slot_tag)
	else begin
		$display("CHECK FAILED time=%0t signal=tag_out expected=%h actual=%h",
			$time, $sampled(slot_tag), $sampled(tag_out));
		stop_fail();
	end

	task automatic issue(input logic [63:0] a, input logic [63:0] b, input logic s,
		input rnd_t r);
		logic [5:0] t;
		t = 6'($urandom);
		@(posedge clk);
		start <= 1'b1;
		sub <= s;
		rnd <= r;
		in_1 <= a;
		in_2 <= b;
		tag <= t;
		pend_res <= expect_res(a, b, s, r);
		pend_exc <= expect_exc(a, b);
		pend_tag <= t;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			start <= 1'b0;
		end
	endtask

	function automatic logic [63:0] rand_word(input int e);
		return {32'hffff_ffff, 1'($urandom), 8'(e), 23'($urandom)};
	endfunction

	initial begin
		int e1, e2;
		void'($urandom(32'h906a_24ec));
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		start <= 1'b0;
		idle(2);
		// back to back with a quarter of the operands near the subnormal range
		for (int i = 0; i < N_RAND; i++) begin
			e1 = ($urandom_range(0, 3) == 0) ? $urandom_range(0, 2) : $urandom_range(0, 254);
			e2 = e1 + int'($urandom_range(0, 48)) - 24;
			e2 = (e2 < 0) ? 0 : ((e2 > 254) ? 254 : e2);
			issue(rand_word(e1), rand_word(e2), 1'($urandom), rnd_t'($urandom_range(0, 4)));
		end
		idle(3);
		issue(QNAN, ONE, 1'b0, RNE);
		issue(ONE, SNAN, 1'b1, RTZ);
		issue(SNAN, PINF, 1'b0, RDN);
		issue(64'h0000_0000_3f80_0000, ONE, 1'b0, RNE);	// unboxed word
		issue(ONE, 64'h1234_5678_7fa0_0000, 1'b0, RUP);
		issue(QNAN, SNAN, 1'b1, RMM);
		issue(NINF, QNAN, 1'b0, RNE);
		idle(2);
		issue(PINF, ONE, 1'b0, RNE);
		issue(ONE, NINF, 1'b1, RTZ);
		issue(PINF, PINF, 1'b0, RNE);
		issue(PINF, PINF, 1'b1, RUP);
		issue(NINF, PINF, 1'b0, RDN);
		issue(NINF, PINF, 1'b1, RMM);
		idle(1);
		for (int m = 0; m < 5; m++) begin
			issue(PMAX, PMAX, 1'b0, rnd_t'(m));
			issue(NMAX, PMAX, 1'b1, rnd_t'(m));
		end
		idle(4);
		for (int m = 0; m < 5; m++) begin
			issue(ONE, ONE, 1'b1, rnd_t'(m));
			issue(PZERO, NZERO, 1'b0, rnd_t'(m));
			issue(NZERO, NZERO, 1'b0, rnd_t'(m));
			issue(NZERO, PZERO, 1'b1, rnd_t'(m));
			idle(1);
		end
		idle(3);
		$display("STATUS: PASS");
		$finish;
	end

	initial begin
		#((N_RAND + N_FIXED + 20) * 8 * 2);
		$display("timeout: the operations did not complete in the expected time");
		stop_fail();
	end

endmodule
